// File: hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    //////////////////////////////////////////////////////////////////////
    // Basic types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    // Opcode numbers taken from the full ISA encoding
    typedef enum logic [4:0] {
        opR    = 5'd0,
        opJ    = 5'd1,
        opBne  = 5'd2,
        opAddi = 5'd5,
        opBlt  = 5'd6,
        opSw   = 5'd7,
        opLw   = 5'd8
    } opcodeE;

    // ALU function field of R-type instructions
    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOpE;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        opcodeE     opcode;
        regIdxT     rd;
        regIdxT     rs;
        regIdxT     rt;
        logic [4:0] shamt;
        aluOpE      aluOp;
        logic [1:0] spare;
    } rTypeT;

    typedef struct packed {
        opcodeE      opcode;
        regIdxT      rd;
        regIdxT      rs;
        logic [16:0] imm;
    } iTypeT;

    typedef struct packed {
        opcodeE      opcode;
        logic [26:0] target;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrU;

    // add r0, r0, r0
    localparam instrU nopInstr = '0;

    //////////////////////////////////////////////////////////////////////
    // Pipeline payloads
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        instrU instr;
        wordT  pcPlus1;
        wordT  dataA;
        wordT  dataB;
    } dxT;

    typedef struct packed {
        instrU instr;
        wordT  aluResult;
        wordT  storeData;
    } xmT;

    typedef struct packed {
        instrU instr;
        wordT  aluResult;
        wordT  loadData;
    } mwT;

    typedef struct packed {
        logic   en;
        regIdxT idx;
        wordT   data;
    } wbT;

    typedef struct packed {
        logic taken;
        wordT target;
    } redirectT;

    // Branches and stores read rd as their second source
    function automatic logic usesRdAsSrc(opcodeE op);
        return (op == opBne) || (op == opBlt) || (op == opSw);
    endfunction

    // True for instructions that really update a register
    function automatic logic writesRd(instrU instr);
        return ((instr.r.opcode == opR) || (instr.r.opcode == opAddi) ||
                (instr.r.opcode == opLw)) && (instr.r.rd != '0);
    endfunction

endpackage

`default_nettype wire

// File: hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter int pcWidth = 12
) (
    input  logic                 clock,
    input  logic                 rstN,
    input  cpuPkg::wordT         imemData,
    input  logic                 loadUseStall,
    input  cpuPkg::redirectT     redirect,
    output logic [pcWidth-1:0]   imemAddr,
    output cpuPkg::instrU        fdInstr,
    output cpuPkg::wordT         fdPcPlus1
);

    cpuPkg::wordT pc;
    cpuPkg::wordT pcPlus1;

    assign pcPlus1  = pc + 32'd1;

    // Instruction memory only sees the low address bits
    assign imemAddr = pc[pcWidth-1:0];

    //////////////////////////////////////////////////////////////////////
    // Program counter and F/D instruction
    //////////////////////////////////////////////////////////////////////

    // Redirect first, so a taken branch wins over a stall
    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc      <= '0;
            fdInstr <= cpuPkg::nopInstr;
        end else if (redirect.taken) begin
            pc      <= redirect.target;
            fdInstr <= cpuPkg::nopInstr;
        end else if (!loadUseStall) begin
            pc      <= pcPlus1;
            fdInstr <= cpuPkg::instrU'(imemData);
        end
    end

    // PC+1 follows the instruction it belongs to
    always_ff @(posedge clock) begin
        if (!loadUseStall) begin
            fdPcPlus1 <= pcPlus1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic           clock,
    input  logic           rstN,
    input  cpuPkg::regIdxT readIdxA,
    input  cpuPkg::regIdxT readIdxB,
    input  cpuPkg::wbT     wb,
    output cpuPkg::wordT   readDataA,
    output cpuPkg::wordT   readDataB
);

    // r0 has no storage
    cpuPkg::wordT regs [31:1];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.idx != '0)) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign readDataA = (readIdxA == '0) ? '0 :
                       (wb.en && (wb.idx == readIdxA)) ? wb.data : regs[readIdxA];
    assign readDataB = (readIdxB == '0) ? '0 :
                       (wb.en && (wb.idx == readIdxB)) ? wb.data : regs[readIdxB];

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic             clock,
    input  logic             rstN,
    input  cpuPkg::instrU    fdInstr,
    input  cpuPkg::wordT     fdPcPlus1,
    input  cpuPkg::wordT     readDataA,
    input  cpuPkg::wordT     readDataB,
    input  cpuPkg::redirectT redirect,
    output cpuPkg::regIdxT   readIdxA,
    output cpuPkg::regIdxT   readIdxB,
    output logic             loadUseStall,
    output cpuPkg::dxT       dx
);

    cpuPkg::instrU  dxInstr;
    cpuPkg::wordT   dxPcPlus1;
    cpuPkg::wordT   dxDataA;
    cpuPkg::wordT   dxDataB;
    logic           rdIsSrc;
    logic           dxIsLoad;
    logic           hitA;
    logic           hitB;

    //////////////////////////////////////////////////////////////////////
    // Source register selection
    //////////////////////////////////////////////////////////////////////

    assign rdIsSrc  = cpuPkg::usesRdAsSrc(fdInstr.r.opcode);
    assign readIdxA = fdInstr.r.rs;
    // bne, blt and sw compare or store rd
    assign readIdxB = rdIsSrc ? fdInstr.r.rd : fdInstr.r.rt;

    //////////////////////////////////////////////////////////////////////
    // Load-use hazard
    //////////////////////////////////////////////////////////////////////

    // Load sitting in execute with a real destination
    assign dxIsLoad = (dxInstr.r.opcode == cpuPkg::opLw) && (dxInstr.r.rd != '0);

    assign hitA     = (readIdxA == dxInstr.r.rd);
    // Store data is patched later in the memory stage
    assign hitB     = (readIdxB == dxInstr.r.rd) && (fdInstr.r.opcode != cpuPkg::opSw);

    assign loadUseStall = dxIsLoad && (hitA || hitB);

    //////////////////////////////////////////////////////////////////////
    // D/X register
    //////////////////////////////////////////////////////////////////////

    // Bubble on stall, squash on redirect
    always_ff @(posedge clock) begin
        if (!rstN) begin
            dxInstr <= cpuPkg::nopInstr;
        end else if (redirect.taken || loadUseStall) begin
            dxInstr <= cpuPkg::nopInstr;
        end else begin
            dxInstr <= fdInstr;
        end
    end

    always_ff @(posedge clock) begin
        dxPcPlus1 <= fdPcPlus1;
        dxDataA   <= readDataA;
        dxDataB   <= readDataB;
    end

    assign dx = '{instr: dxInstr, pcPlus1: dxPcPlus1, dataA: dxDataA, dataB: dxDataB};

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic             clock,
    input  logic             rstN,
    input  cpuPkg::dxT       dx,
    input  cpuPkg::instrU    memFwdInstr,
    input  cpuPkg::wordT     memFwdData,
    input  cpuPkg::wbT       wbFwd,
    output cpuPkg::redirectT redirect,
    output cpuPkg::xmT       xm
);

    cpuPkg::opcodeE opcode;
    cpuPkg::aluOpE  aluSel;
    cpuPkg::regIdxT srcA;
    cpuPkg::regIdxT srcB;
    cpuPkg::wordT   opA;
    cpuPkg::wordT   opB;
    cpuPkg::wordT   immExt;
    cpuPkg::wordT   aluB;
    cpuPkg::wordT   aluResult;
    logic           memHitA;
    logic           memHitB;
    logic           useImm;
    logic           branchTaken;
    logic           isJump;
    cpuPkg::instrU  xmInstr;
    cpuPkg::wordT   xmAluResult;
    cpuPkg::wordT   xmStoreData;

    assign opcode = dx.instr.r.opcode;
    assign srcA   = dx.instr.r.rs;
    assign srcB   = cpuPkg::usesRdAsSrc(opcode) ? dx.instr.r.rd : dx.instr.r.rt;

    //////////////////////////////////////////////////////////////////////
    // Operand bypass
    //////////////////////////////////////////////////////////////////////

    // Memory stage is younger, so it has priority over writeback
    assign memHitA = cpuPkg::writesRd(memFwdInstr) && (memFwdInstr.r.rd == srcA);
    assign memHitB = cpuPkg::writesRd(memFwdInstr) && (memFwdInstr.r.rd == srcB);

    assign opA = memHitA ? memFwdData :
                 (wbFwd.en && (wbFwd.idx == srcA)) ? wbFwd.data : dx.dataA;
    assign opB = memHitB ? memFwdData :
                 (wbFwd.en && (wbFwd.idx == srcB)) ? wbFwd.data : dx.dataB;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    assign immExt = {{15{dx.instr.i.imm[16]}}, dx.instr.i.imm};

    // Address arithmetic and addi go through the adder
    assign useImm = (opcode == cpuPkg::opAddi) || (opcode == cpuPkg::opLw) ||
                    (opcode == cpuPkg::opSw);
    assign aluB   = useImm ? immExt : opB;
    assign aluSel = (opcode == cpuPkg::opR) ? dx.instr.r.aluOp : cpuPkg::aluAdd;

    always_comb begin
        case (aluSel)
            cpuPkg::aluAdd: aluResult = opA + aluB;
            cpuPkg::aluSub: aluResult = opA - aluB;
            cpuPkg::aluAnd: aluResult = opA & aluB;
            cpuPkg::aluOr:  aluResult = opA | aluB;
            cpuPkg::aluSll: aluResult = opA << dx.instr.r.shamt;
            cpuPkg::aluSra: aluResult = cpuPkg::wordT'($signed(opA) >>> dx.instr.r.shamt);
            default:        aluResult = opA + aluB;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////////////////////////

    // rd sits in opB, rs in opA
    assign branchTaken = ((opcode == cpuPkg::opBne) && (opB != opA)) ||
                         ((opcode == cpuPkg::opBlt) && ($signed(opB) < $signed(opA)));
    assign isJump      = (opcode == cpuPkg::opJ);

    assign redirect.taken  = branchTaken || isJump;
    // Jump target is absolute, branch offset is from PC+1
    assign redirect.target = isJump ? {5'b0, dx.instr.j.target} : dx.pcPlus1 + immExt;

    //////////////////////////////////////////////////////////////////////
    // X/M register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rstN) begin
            xmInstr <= cpuPkg::nopInstr;
        end else begin
            xmInstr <= dx.instr;
        end
    end

    // Store data may still be patched from writeback
    always_ff @(posedge clock) begin
        xmAluResult <= aluResult;
        xmStoreData <= opB;
    end

    assign xm = '{instr: xmInstr, aluResult: xmAluResult, storeData: xmStoreData};

endmodule

`default_nettype wire

// File: hdl/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  logic          clock,
    input  logic          rstN,
    input  cpuPkg::xmT    xm,
    input  cpuPkg::wordT  dmemReadData,
    output cpuPkg::wordT  dmemAddr,
    output cpuPkg::wordT  dmemWriteData,
    output logic          dmemWrite,
    output cpuPkg::instrU memFwdInstr,
    output cpuPkg::wordT  memFwdData,
    output cpuPkg::wbT    wb
);

    cpuPkg::instrU mwInstr;
    cpuPkg::wordT  mwAluResult;
    cpuPkg::wordT  mwLoadData;
    cpuPkg::mwT    mw;
    logic          storeBypass;

    //////////////////////////////////////////////////////////////////////
    // Data memory drive
    //////////////////////////////////////////////////////////////////////

    assign dmemAddr    = xm.aluResult;
    assign dmemWrite   = (xm.instr.r.opcode == cpuPkg::opSw);

    // Covers a load or ALU op retiring right behind the store
    assign storeBypass   = wb.en && (wb.idx == xm.instr.r.rd);
    assign dmemWriteData = storeBypass ? wb.data : xm.storeData;

    // Execute bypass source
    assign memFwdInstr = xm.instr;
    assign memFwdData  = xm.aluResult;

    //////////////////////////////////////////////////////////////////////
    // M/W register and writeback
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rstN) begin
            mwInstr <= cpuPkg::nopInstr;
        end else begin
            mwInstr <= xm.instr;
        end
    end

    always_ff @(posedge clock) begin
        mwAluResult <= xm.aluResult;
        mwLoadData  <= dmemReadData;
    end

    assign mw = '{instr: mwInstr, aluResult: mwAluResult, loadData: mwLoadData};

    // Loads return memory data, all else the ALU result
    assign wb = '{en:   cpuPkg::writesRd(mw.instr),
                  idx:  mw.instr.r.rd,
                  data: (mw.instr.r.opcode == cpuPkg::opLw) ? mw.loadData : mw.aluResult};

endmodule

`default_nettype wire

// File: hdl/pipelineCpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu #(
    parameter int pcWidth = 12
) (
    input  logic               clock,
    input  logic               rstN,
    input  cpuPkg::wordT       imemData,
    input  cpuPkg::wordT       dmemReadData,
    output logic [pcWidth-1:0] imemAddr,
    output cpuPkg::wordT       dmemAddr,
    output cpuPkg::wordT       dmemWriteData,
    output logic               dmemWrite
);

    //////////////////////////////////////////////////////////////////////
    // Inter-stage wiring
    //////////////////////////////////////////////////////////////////////

    cpuPkg::instrU    fdInstr;
    cpuPkg::wordT     fdPcPlus1;
    logic             loadUseStall;
    cpuPkg::redirectT redirect;
    cpuPkg::regIdxT   readIdxA;
    cpuPkg::regIdxT   readIdxB;
    cpuPkg::wordT     readDataA;
    cpuPkg::wordT     readDataB;
    cpuPkg::dxT       dx;
    cpuPkg::xmT       xm;
    cpuPkg::instrU    memFwdInstr;
    cpuPkg::wordT     memFwdData;
    cpuPkg::wbT       wb;

    // Input side
    fetchStage #(.pcWidth(pcWidth)) fetch (
        .clock(clock), .rstN(rstN), .imemData(imemData),
        .loadUseStall(loadUseStall), .redirect(redirect),
        .imemAddr(imemAddr), .fdInstr(fdInstr), .fdPcPlus1(fdPcPlus1)
    );

    // Processing
    decodeStage decode (
        .clock(clock), .rstN(rstN), .fdInstr(fdInstr), .fdPcPlus1(fdPcPlus1),
        .readDataA(readDataA), .readDataB(readDataB), .redirect(redirect),
        .readIdxA(readIdxA), .readIdxB(readIdxB),
        .loadUseStall(loadUseStall), .dx(dx)
    );

    regFile regs (
        .clock(clock), .rstN(rstN), .readIdxA(readIdxA), .readIdxB(readIdxB),
        .wb(wb), .readDataA(readDataA), .readDataB(readDataB)
    );

    executeStage execute (
        .clock(clock), .rstN(rstN), .dx(dx),
        .memFwdInstr(memFwdInstr), .memFwdData(memFwdData), .wbFwd(wb),
        .redirect(redirect), .xm(xm)
    );

    // Output side, memory and register writeback
    memWbStage memWb (
        .clock(clock), .rstN(rstN), .xm(xm), .dmemReadData(dmemReadData),
        .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData), .dmemWrite(dmemWrite),
        .memFwdInstr(memFwdInstr), .memFwdData(memFwdData), .wb(wb)
    );

endmodule

`default_nettype wire

// File: test/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int halfPeriod  = 4,
    parameter int resetCycles = 2
) (
    output logic clock,
    output logic rstN
);

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever #(halfPeriod) clock = ~clock;
    end

    // Release 1 ns after an edge, like every other input
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clock);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/pipelineCpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineCpuAssert #(
    parameter int pcWidth = 12
) (
    input logic               clock,
    input logic               rstN,
    input logic               dmemWrite,
    input logic               loadUseStall,
    input logic [pcWidth-1:0] imemAddr,
    input cpuPkg::redirectT   redirect,
    input cpuPkg::wbT         wb
);

    // Store strobe must be clean once running
    dmemWriteKnown: assert property (@(posedge clock) disable iff (!rstN)
        !$isunknown(dmemWrite))
        else $error("dmemWrite is unknown after reset");

    // Pipeline comes out of reset holding only nops
    noStoreAfterReset: assert property (@(posedge clock)
        $rose(rstN) |-> !dmemWrite)
        else $error("dmemWrite high in the first cycle after reset");

    // Stall freezes the PC unless a redirect wins
    stallHoldsPc: assert property (@(posedge clock) disable iff (!rstN)
        (loadUseStall && !redirect.taken) |=> (imemAddr == $past(imemAddr)))
        else $error("imemAddr moved during a load-use stall");

    // r0 is never a writeback target
    noWriteToZero: assert property (@(posedge clock) disable iff (!rstN)
        wb.en |-> (wb.idx != '0))
        else $error("writeback enabled for register 0");

endmodule

bind pipelineCpu pipelineCpuAssert #(.pcWidth(pcWidth)) checks (
    .clock(clock), .rstN(rstN), .dmemWrite(dmemWrite), .loadUseStall(loadUseStall),
    .imemAddr(imemAddr), .redirect(redirect), .wb(wb)
);

`default_nettype wire

// File: test/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int pcWidth     = 12;
    localparam int memWords    = 4096;
    localparam int testCount   = 5;
    localparam int testCycles  = 200;
    localparam int drainCycles = 8;
    // Every test may use its whole budget, the rest covers reset and drain
    localparam int cycleLimit  = testCount * testCycles + 200;

    logic               clock;
    logic               rstN;
    logic               testRstN;
    logic               dutRstN;
    logic [pcWidth-1:0] imemAddr;
    cpuPkg::wordT       imemData;
    cpuPkg::wordT       dmemReadData;
    cpuPkg::wordT       dmemAddr;
    cpuPkg::wordT       dmemWriteData;
    logic               dmemWrite;

    cpuPkg::wordT instrMem [memWords];
    cpuPkg::wordT dataMem [memWords];
    // Seen and predicted stores, in program order
    cpuPkg::wordT gotAddr [$];
    cpuPkg::wordT gotData [$];
    cpuPkg::wordT expAddr [$];
    cpuPkg::wordT expData [$];

    cpuPkg::wordT lfsrState;
    int           progLen;
    int           testErrors;
    int           errorCount;
    int           failedTests;
    int           cycleCount = 0;

    tbClock clockGen (.clock(clock), .rstN(rstN));

    // Power-on reset combined with the per-test pulse
    assign dutRstN = rstN && testRstN;

    pipelineCpu #(.pcWidth(pcWidth)) UUT (
        .clock(clock), .rstN(dutRstN), .imemData(imemData), .dmemReadData(dmemReadData),
        .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData),
        .dmemWrite(dmemWrite)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory models and store log
    //////////////////////////////////////////////////////////////////////

    assign imemData     = instrMem[imemAddr];
    assign dmemReadData = dataMem[dmemAddr[11:0]];

    always @(posedge clock) begin
        if (!dutRstN) begin
            // Fill word carries its own address
            for (int i = 0; i < memWords; i++) begin
                dataMem[i] <= {20'hda7a0, i[11:0]};
            end
            gotAddr.delete();
            gotData.delete();
        end else if (dmemWrite) begin
            dataMem[dmemAddr[11:0]] <= dmemWriteData;
            gotAddr.push_back(dmemAddr);
            gotData.push_back(dmemWriteData);
        end
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Run stopped after %0d cycles, the tests did not complete", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operands and instruction encoding
    //////////////////////////////////////////////////////////////////////

    // Taps 32 22 2 1
    function automatic cpuPkg::wordT lfsrStep(input cpuPkg::wordT state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int count, output cpuPkg::wordT value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // 16-bit operand, sign-extended
    task automatic randOperand(output cpuPkg::wordT value);
        cpuPkg::wordT raw;
        takeBits(16, raw);
        value = {{16{raw[15]}}, raw[15:0]};
    endtask

    function automatic cpuPkg::wordT encR(input cpuPkg::aluOpE op, input int rd, input int rs,
                                          input int rt, input int shamt);
        return {cpuPkg::opR, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], op, 2'b00};
    endfunction

    function automatic cpuPkg::wordT encI(input cpuPkg::opcodeE op, input int rd, input int rs,
                                          input cpuPkg::wordT imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic cpuPkg::wordT encJ(input int target);
        return {cpuPkg::opJ, target[26:0]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and test framing
    //////////////////////////////////////////////////////////////////////

    task automatic checkWord(input string name, input cpuPkg::wordT got,
                             input cpuPkg::wordT exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkAddr(input string name, input cpuPkg::wordT got,
                             input cpuPkg::wordT exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic emit(input cpuPkg::wordT instr);
        instrMem[progLen] = instr;
        progLen++;
    endtask

    task automatic expectStore(input cpuPkg::wordT addr, input cpuPkg::wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // Holds the core in reset while a new program goes in
    task automatic beginTest();
        int i;
        @(posedge clock);
        #1 testRstN = 1'b0;
        // Unused words jump to themselves
        for (i = 0; i < memWords; i++) begin
            instrMem[i] = encJ(i);
        end
        progLen    = 0;
        testErrors = 0;
        expAddr.delete();
        expData.delete();
    endtask

    task automatic finishTest(input string name);
        int waited;
        int i;
        waited = 0;
        repeat (2) @(posedge clock);
        #1 testRstN = 1'b1;
        while ((gotAddr.size() < expAddr.size()) && (waited < testCycles)) begin
            @(posedge clock);
            #1;
            waited++;
        end
        // Stores from a missed squash would still be in flight
        repeat (drainCycles) @(posedge clock);
        #1;
        if (gotAddr.size() != expAddr.size()) begin
            $display("%s: expected %0d stores but saw %0d", name, expAddr.size(),
                     gotAddr.size());
            testErrors++;
        end
        for (i = 0; (i < expAddr.size()) && (i < gotAddr.size()); i++) begin
            checkAddr($sformatf("dmemAddr of store %0d", i), gotAddr[i], expAddr[i]);
            checkWord($sformatf("dmemWriteData of store %0d", i), gotData[i], expData[i]);
        end
        if (testErrors == 0) begin
            $display("%s: passed with %0d stores", name, gotAddr.size());
        end else begin
            $display("%s: failed with %0d errors", name, testErrors);
            failedTests++;
        end
        errorCount += testErrors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    // Every ALU op reads the result just ahead of it
    task automatic aluChainTest();
        cpuPkg::wordT a, b, s1, s2, c3, c4, c5, c6, c7, c8;
        int r;
        randOperand(a);
        randOperand(b);
        takeBits(5, s1);
        takeBits(5, s2);
        beginTest();
        emit(encI(cpuPkg::opAddi, 1, 0, a));
        emit(encI(cpuPkg::opAddi, 2, 0, b));
        emit(encR(cpuPkg::aluAdd, 3, 1, 2, 0));
        emit(encR(cpuPkg::aluSub, 4, 3, 2, 0));
        emit(encR(cpuPkg::aluAnd, 5, 4, 3, 0));
        emit(encR(cpuPkg::aluOr, 6, 5, 4, 0));
        emit(encR(cpuPkg::aluSll, 7, 6, 0, s1));
        emit(encR(cpuPkg::aluSra, 8, 7, 0, s2));
        for (r = 3; r <= 8; r++) begin
            emit(encI(cpuPkg::opSw, r, 0, 16 + r));
        end
        emit(encJ(progLen));
        c3 = a + b;
        c4 = c3 - b;
        c5 = c4 & c3;
        c6 = c5 | c4;
        c7 = c6 << s1;
        c8 = $signed(c7) >>> s2;
        expectStore(19, c3);
        expectStore(20, c4);
        expectStore(21, c5);
        expectStore(22, c6);
        expectStore(23, c7);
        expectStore(24, c8);
        finishTest("ALU chain");
    endtask

    // Second store takes its data from a load retiring behind it
    task automatic storeBypassTest();
        cpuPkg::wordT v, base;
        randOperand(v);
        takeBits(10, base);
        beginTest();
        emit(encI(cpuPkg::opAddi, 10, 0, base));
        emit(encI(cpuPkg::opAddi, 9, 0, v));
        emit(encI(cpuPkg::opSw, 9, 10, 7));
        emit(encI(cpuPkg::opLw, 11, 10, 7));
        emit(encI(cpuPkg::opSw, 11, 10, 8));
        emit(encJ(progLen));
        expectStore(base + 7, v);
        expectStore(base + 8, v);
        finishTest("Store-data bypass");
    endtask

    task automatic loadUseTest();
        cpuPkg::wordT x, y, addr;
        randOperand(x);
        randOperand(y);
        takeBits(11, addr);
        beginTest();
        emit(encI(cpuPkg::opAddi, 13, 0, x));
        emit(encI(cpuPkg::opAddi, 14, 0, y));
        emit(encI(cpuPkg::opSw, 13, 0, addr));
        emit(encI(cpuPkg::opLw, 15, 0, addr));
        emit(encR(cpuPkg::aluAdd, 16, 15, 14, 0));
        emit(encI(cpuPkg::opSw, 16, 0, addr + 1));
        emit(encJ(progLen));
        expectStore(addr, x);
        expectStore(addr + 1, x + y);
        finishTest("Load-use");
    endtask

    task automatic branchTest();
        cpuPkg::wordT p, q, n1, n2, bits;
        randOperand(p);
        takeBits(14, bits);
        // Flip low bits only, so q stays a valid immediate and differs
        q = p ^ (bits + 1);
        takeBits(14, bits);
        n1 = 32'hffff_8000 + bits;
        takeBits(14, bits);
        n2 = n1 + 1 + bits;
        beginTest();
        emit(encI(cpuPkg::opAddi, 1, 0, p));
        emit(encI(cpuPkg::opAddi, 2, 0, q));
        emit(encI(cpuPkg::opAddi, 3, 0, n1));
        emit(encI(cpuPkg::opAddi, 4, 0, n2));
        emit(encI(cpuPkg::opBne, 1, 2, 2));
        emit(encI(cpuPkg::opSw, 1, 0, 40));
        emit(encI(cpuPkg::opSw, 2, 0, 41));
        emit(encI(cpuPkg::opSw, 1, 0, 50));
        emit(encI(cpuPkg::opBne, 1, 1, 2));
        emit(encI(cpuPkg::opSw, 1, 0, 42));
        emit(encI(cpuPkg::opSw, 2, 0, 43));
        emit(encI(cpuPkg::opBlt, 3, 4, 2));
        emit(encI(cpuPkg::opSw, 3, 0, 44));
        emit(encI(cpuPkg::opSw, 4, 0, 45));
        emit(encI(cpuPkg::opSw, 3, 0, 51));
        // Zero is only below a negative value when compared unsigned
        emit(encI(cpuPkg::opBlt, 0, 3, 2));
        emit(encI(cpuPkg::opSw, 3, 0, 46));
        emit(encI(cpuPkg::opSw, 4, 0, 47));
        emit(encJ(progLen));
        // Target stores, then fall-through markers of the untaken branches
        expectStore(50, p);
        expectStore(42, p);
        expectStore(43, q);
        expectStore(51, n1);
        expectStore(46, n1);
        expectStore(47, n2);
        finishTest("Branches");
    endtask

    task automatic jumpTest();
        cpuPkg::wordT v;
        randOperand(v);
        beginTest();
        emit(encI(cpuPkg::opAddi, 1, 0, v));
        emit(encI(cpuPkg::opSw, 1, 0, 59));
        emit(encJ(6));
        emit(encI(cpuPkg::opSw, 1, 0, 60));
        emit(encI(cpuPkg::opSw, 1, 0, 61));
        emit(encI(cpuPkg::opSw, 1, 0, 62));
        emit(encI(cpuPkg::opSw, 1, 0, 63));
        emit(encJ(progLen));
        expectStore(59, v);
        expectStore(63, v);
        finishTest("Jump");
    endtask

    initial begin
        testRstN    = 1'b0;
        lfsrState   = 32'hf31b_1b66;
        progLen     = 0;
        testErrors  = 0;
        errorCount  = 0;
        failedTests = 0;
        aluChainTest();
        storeBypassTest();
        loadUseTest();
        branchTest();
        jumpTest();
        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/pipelineCpu.sv
test/tbClock.sv
test/pipelineCpu_assert.sv
test/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the pipelined CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpuTb -f filelist.f -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
